// File: source/mem_pkg.sv
`default_nettype none

// RAM addressing as seen from the ST core side
package mem_pkg;

  // cpu word address runs 23:1
  localparam int ram_addr_hi = 23;

  // sdram word address runs 22:1, so 8MB of words
  localparam int ram_word_bits = 22;

  // cold-boot scrambling touches word address bits 4:3
  localparam int scramble_lo = 3;   // lowest scrambled bit
  localparam int scramble_bits = 2; // counter width, also slice width

endpackage

`default_nettype wire

// File: source/disk_pkg.sv
`default_nettype none

// sd card requests, who owns the sector engine, and boot wait
package disk_pkg;

  localparam int sd_lba_bits = 32;  // sector number
  localparam int sd_img_bits = 32;  // image file length
  localparam int sd_drives = 2;     // drives per source, fdc and acsi alike

  // 2 s at 32 MHz before the core boots without an image
  localparam int unsigned boot_wait_default = 64_000_000;

  // last source that issued a sector request
  typedef enum logic {
    owner_fdc  = 1'b0,
    owner_acsi = 1'b1
  } req_owner_t;

  // boot gate
  typedef enum logic {
    boot_waiting = 1'b0, // no image yet, timer running
    boot_ready   = 1'b1  // sticky until arst_n
  } boot_state_t;

endpackage

`default_nettype wire

// File: source/ram_scrambler.sv
`default_nettype none

// cold boot means ram contents go stale; shifting a couple of address
// lines on every cold boot makes the old contents unreachable
module ram_scrambler import mem_pkg::*; (
  input  wire                     clk_32,
  input  wire                     arst_n,
  input  wire [ram_addr_hi:1]     ram_addr,   // word address from the core
  input  wire                     ram_ras_n,  // row strobe, low active
  input  wire                     coldboot,   // system_reset[1] from the osd
  output logic [ram_word_bits:1]  ram_addr_s, // scrambled sdram word address
  output logic                    ram_cs      // sdram request
);

  logic                     coldboot_d;   // previous sample of coldboot
  logic [scramble_bits-1:0] scramble_cnt; // cold boot count that wraps
  logic                     coldboot_rise;

  assign coldboot_rise = coldboot && !coldboot_d; // low then high

  always_ff @(posedge clk_32 or negedge arst_n) begin
    if (!arst_n) begin
      coldboot_d   <= 1'b0;
      scramble_cnt <= '0; // no scramble after power up
    end else begin
      coldboot_d <= coldboot;
      if (coldboot_rise)
        scramble_cnt <= scramble_cnt + 1'b1; // holding the flag adds nothing
    end
  end

  // xor bits 4:3 and pass the rest straight
  always_comb begin
    ram_addr_s = ram_addr[ram_word_bits:1];
    ram_addr_s[scramble_lo +: scramble_bits] =
      ram_addr[scramble_lo +: scramble_bits] ^ scramble_cnt;
  end

  // bit 23 set is outside the 8MB sdram (rom, io space)
  assign ram_cs = !ram_ras_n && !ram_addr[ram_addr_hi];

  // counter only moves right after a cold boot edge
  a_scramble_on_edge : assert property (
    @(posedge clk_32) disable iff (!arst_n)
    !$stable(scramble_cnt) |-> $past(coldboot_rise)
  ) else $error("scramble counter moved without a cold boot edge");

endmodule

`default_nettype wire

// File: source/boot_gate.sv
`default_nettype none

// hold the st core in reset until the mcu had a chance to mount a
// default disk image, then release on all the other ready sources too
module boot_gate import disk_pkg::*; #(
  parameter int unsigned boot_wait_cycles = boot_wait_default // clk_32 cycles
) (
  input  wire                    clk_32,
  input  wire                    arst_n,
  input  wire [sd_img_bits-1:0]  sd_img_size,  // nonzero once an image is mounted
  input  wire                    ram_ready,    // sdram init done
  input  wire                    flash_ready,  // tos flash readable
  input  wire                    reset_button, // user button, high = reset
  input  wire                    osd_reset,    // system_reset[0] from the osd
  output logic                   core_resb     // st core reset, low active
);

  boot_state_t state;
  logic [31:0] wait_cnt; // cycles spent in boot_waiting
  logic        img_mounted;
  logic        wait_done;
  logic        sd_ready;

  assign img_mounted = sd_img_size != '0;
  assign wait_done   = wait_cnt == 32'(boot_wait_cycles); // timeout edge

  always_ff @(posedge clk_32 or negedge arst_n) begin
    if (!arst_n) begin
      state    <= boot_waiting;
      wait_cnt <= '0;
    end else begin
      case (state)
        boot_waiting: begin
          if (img_mounted || wait_done)
            state <= boot_ready; // image found or gave up waiting
          else
            wait_cnt <= wait_cnt + 32'd1;
        end
        boot_ready: begin
          state <= boot_ready; // sticky until arst_n
        end
        default: begin
          state <= boot_waiting;
        end
      endcase
    end
  end

  assign sd_ready = state == boot_ready;

  // every source must agree before the st runs
  assign core_resb = sd_ready
                  && ram_ready
                  && flash_ready
                  && !reset_button
                  && !osd_reset;

  // no boot while still waiting for the sd card
  a_no_boot_waiting : assert property (
    @(posedge clk_32) disable iff (!arst_n)
    state == boot_waiting |-> !core_resb
  ) else $error("core released before sd ready");

endmodule

`default_nettype wire

// File: source/sd_request_steer.sv
`default_nettype none

// floppy and acsi share one sd sector engine. the engine only sees the
// start vectors, so sector number and write byte must come from whoever
// issued the last request
module sd_request_steer import disk_pkg::*; (
  input  wire                      clk_32,
  input  wire                      arst_n,

  // floppy controller side
  input  wire [sd_drives-1:0]      fdc_rd,       // read request per drive
  input  wire [sd_drives-1:0]      fdc_wr,       // write request per drive
  input  wire [sd_lba_bits-1:0]    fdc_lba,
  input  wire [7:0]                fdc_wr_byte,  // sector data toward card

  // acsi hard disk side
  input  wire [sd_drives-1:0]      acsi_rd,
  input  wire [sd_drives-1:0]      acsi_wr,
  input  wire [sd_lba_bits-1:0]    acsi_lba,
  input  wire [7:0]                acsi_wr_byte,

  // toward the sector engine
  output logic [2*sd_drives-1:0]   rstart,       // acsi high half, fdc low half
  output logic [2*sd_drives-1:0]   wstart,
  output logic [sd_lba_bits-1:0]   sd_sector,
  output logic [7:0]               sd_wr_byte
);

  req_owner_t owner_q;   // last requester
  logic       fdc_req;   // any floppy request bit
  logic       acsi_req;  // any acsi request bit
  logic       is_acsi;   // effective owner this cycle

  assign fdc_req  = |{fdc_rd, fdc_wr};
  assign acsi_req = |{acsi_rd, acsi_wr};

  always_ff @(posedge clk_32 or negedge arst_n) begin
    if (!arst_n) begin
      owner_q <= owner_fdc;
    end else begin
      // floppy checked first so it wins a tie
      if (fdc_req)
        owner_q <= owner_fdc;
      else if (acsi_req)
        owner_q <= owner_acsi;
      // no request keeps the owner so a held transfer stays steered
    end
  end

  // a fresh acsi request steers in the same cycle
  assign is_acsi = acsi_req || (owner_q == owner_acsi);

  assign sd_sector  = is_acsi ? acsi_lba : fdc_lba;
  assign sd_wr_byte = is_acsi ? acsi_wr_byte : fdc_wr_byte;

  // engine numbers drives 0..1 floppy, 2..3 acsi
  assign rstart = {acsi_rd, fdc_rd};
  assign wstart = {acsi_wr, fdc_wr};

  // the core never asks both at once; steer picks a side anyway
  a_one_source : assert property (
    @(posedge clk_32) disable iff (!arst_n)
    !(fdc_req && acsi_req)
  ) else $error("floppy and acsi request in the same cycle");

endmodule

`default_nettype wire

// File: source/st_glue.sv
`default_nettype none

// glue between the atari st core, the sdram and the sd card engine
// three independent blocks, one clock
module st_glue import mem_pkg::*, disk_pkg::*; #(
  parameter int unsigned boot_wait_cycles = boot_wait_default
) (
  input  wire                      clk_32,
  input  wire                      arst_n,

  // st core ram port
  input  wire [ram_addr_hi:1]      ram_addr,
  input  wire                      ram_ras_n,

  // osd control, bit 1 cold boot, bit 0 reset
  input  wire [1:0]                system_reset,

  // boot readiness
  input  wire [sd_img_bits-1:0]    sd_img_size,   // from the sd card engine
  input  wire                      ram_ready,
  input  wire                      flash_ready,
  input  wire                      reset_button,

  // floppy requests
  input  wire [sd_drives-1:0]      fdc_rd,
  input  wire [sd_drives-1:0]      fdc_wr,
  input  wire [sd_lba_bits-1:0]    fdc_lba,
  input  wire [7:0]                fdc_wr_byte,

  // acsi requests
  input  wire [sd_drives-1:0]      acsi_rd,
  input  wire [sd_drives-1:0]      acsi_wr,
  input  wire [sd_lba_bits-1:0]    acsi_lba,
  input  wire [7:0]                acsi_wr_byte,

  // sdram side
  output wire [ram_word_bits:1]    ram_addr_s,    // scrambled word address
  output wire                      ram_cs,

  // st core reset, low active
  output wire                      core_resb,

  // sd sector engine side
  output wire [2*sd_drives-1:0]    rstart,
  output wire [2*sd_drives-1:0]    wstart,
  output wire [sd_lba_bits-1:0]    sd_sector,
  output wire [7:0]                sd_wr_byte
);

  // cold boot scrambling of the sdram address
  ram_scrambler ram_scrambler_inst (
    .clk_32     (clk_32),
    .arst_n     (arst_n),
    .ram_addr   (ram_addr),
    .ram_ras_n  (ram_ras_n),
    .coldboot   (system_reset[1]),
    .ram_addr_s (ram_addr_s),
    .ram_cs     (ram_cs)
  );

  // hold the core until sd image or timeout
  boot_gate #(
    .boot_wait_cycles (boot_wait_cycles)
  ) boot_gate_inst (
    .clk_32       (clk_32),
    .arst_n       (arst_n),
    .sd_img_size  (sd_img_size),
    .ram_ready    (ram_ready),
    .flash_ready  (flash_ready),
    .reset_button (reset_button),
    .osd_reset    (system_reset[0]),
    .core_resb    (core_resb)
  );

  // fdc/acsi share of the sector engine
  sd_request_steer sd_request_steer_inst (
    .clk_32       (clk_32),
    .arst_n       (arst_n),
    .fdc_rd       (fdc_rd),
    .fdc_wr       (fdc_wr),
    .fdc_lba      (fdc_lba),
    .fdc_wr_byte  (fdc_wr_byte),
    .acsi_rd      (acsi_rd),
    .acsi_wr      (acsi_wr),
    .acsi_lba     (acsi_lba),
    .acsi_wr_byte (acsi_wr_byte),
    .rstart       (rstart),
    .wstart       (wstart),
    .sd_sector    (sd_sector),
    .sd_wr_byte   (sd_wr_byte)
  );

endmodule

`default_nettype wire

// File: bench/st_glue_tb.sv
`default_nettype none

// testbench for st_glue, every step comes from bench/st_glue_stim.txt
module st_glue_tb import mem_pkg::*, disk_pkg::*; ();

  localparam int unsigned boot_wait = 40;     // short boot wait for simulation
  localparam int unsigned drive_delay = 10;   // after the rising edge
  localparam int unsigned check_delay = 80;   // lands 10 before the next edge

  logic                   clk_32;
  logic                   arst_n;
  logic [ram_addr_hi:1]   ram_addr;
  logic                   ram_ras_n;
  logic [1:0]             system_reset;
  logic [sd_img_bits-1:0] sd_img_size;
  logic                   ram_ready;
  logic                   flash_ready;
  logic                   reset_button;
  logic [sd_drives-1:0]   fdc_rd;
  logic [sd_drives-1:0]   fdc_wr;
  logic [sd_lba_bits-1:0] fdc_lba;
  logic [7:0]             fdc_wr_byte;
  logic [sd_drives-1:0]   acsi_rd;
  logic [sd_drives-1:0]   acsi_wr;
  logic [sd_lba_bits-1:0] acsi_lba;
  logic [7:0]             acsi_wr_byte;

  wire [ram_word_bits:1]  ram_addr_s;
  wire                    ram_cs;
  wire                    core_resb;
  wire [2*sd_drives-1:0]  rstart;
  wire [2*sd_drives-1:0]  wstart;
  wire [sd_lba_bits-1:0]  sd_sector;
  wire [7:0]              sd_wr_byte;

  // one stim line, inputs then expected outputs
  typedef struct packed {
    logic [31:0]              tag;
    logic [31:0]              rep;          // cycles this line is held
    logic                     arst_n;
    logic [ram_addr_hi-1:0]   ram_addr;
    logic                     ram_ras_n;
    logic [1:0]               system_reset;
    logic [sd_img_bits-1:0]   img;
    logic                     ram_ready;
    logic                     flash_ready;
    logic                     reset_button;
    logic [sd_drives-1:0]     fdc_rd;
    logic [sd_drives-1:0]     fdc_wr;
    logic [sd_lba_bits-1:0]   fdc_lba;
    logic [7:0]               fdc_byte;
    logic [sd_drives-1:0]     acsi_rd;
    logic [sd_drives-1:0]     acsi_wr;
    logic [sd_lba_bits-1:0]   acsi_lba;
    logic [7:0]               acsi_byte;
    logic [3:0]               rnd;          // fields replaced by $urandom
    logic [ram_word_bits-1:0] exp_addr_s;
    logic                     exp_cs;
    logic                     exp_resb;
    logic [2*sd_drives-1:0]   exp_rstart;
    logic [2*sd_drives-1:0]   exp_wstart;
    logic [sd_lba_bits-1:0]   exp_sector;
    logic [7:0]               exp_byte;
    logic [6:0]               mask;         // which outputs get compared
  } step_t;

  step_t       steps[$];
  logic        stim_loaded;
  int unsigned total_cycles;  // sum of all rep fields
  int unsigned check_count;
  int unsigned seed_dummy;

  st_glue #(
    .boot_wait_cycles (boot_wait)
  ) st_glue_inst (
    .clk_32       (clk_32),
    .arst_n       (arst_n),
    .ram_addr     (ram_addr),
    .ram_ras_n    (ram_ras_n),
    .system_reset (system_reset),
    .sd_img_size  (sd_img_size),
    .ram_ready    (ram_ready),
    .flash_ready  (flash_ready),
    .reset_button (reset_button),
    .fdc_rd       (fdc_rd),
    .fdc_wr       (fdc_wr),
    .fdc_lba      (fdc_lba),
    .fdc_wr_byte  (fdc_wr_byte),
    .acsi_rd      (acsi_rd),
    .acsi_wr      (acsi_wr),
    .acsi_lba     (acsi_lba),
    .acsi_wr_byte (acsi_wr_byte),
    .ram_addr_s   (ram_addr_s),
    .ram_cs       (ram_cs),
    .core_resb    (core_resb),
    .rstart       (rstart),
    .wstart       (wstart),
    .sd_sector    (sd_sector),
    .sd_wr_byte   (sd_wr_byte)
  );

  initial begin
    clk_32 = 1'b0;
    forever #50 clk_32 = ~clk_32; // 100 per cycle
  end

  // parse the stim file into steps, comment and blank lines skipped
  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [0:26];
    step_t       s;
    fd = $fopen("bench/st_glue_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/st_glue_stim.txt for reading");
      $display("Some tests failed");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
        n = $sscanf(line,
          "%d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
          f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
          f[19], f[20], f[21], f[22], f[23], f[24], f[25], f[26]);
        if (n != 27) begin
          $display("stim line has %0d fields instead of 27: %s", n, line);
          $display("Some tests failed");
          $fatal(1, "malformed stimulus");
        end
        s.tag          = f[0];
        s.rep          = f[1];
        s.arst_n       = f[2][0];
        s.ram_addr     = f[3][ram_addr_hi-1:0];
        s.ram_ras_n    = f[4][0];
        s.system_reset = f[5][1:0];
        s.img          = f[6];
        s.ram_ready    = f[7][0];
        s.flash_ready  = f[8][0];
        s.reset_button = f[9][0];
        s.fdc_rd       = f[10][sd_drives-1:0];
        s.fdc_wr       = f[11][sd_drives-1:0];
        s.fdc_lba      = f[12];
        s.fdc_byte     = f[13][7:0];
        s.acsi_rd      = f[14][sd_drives-1:0];
        s.acsi_wr      = f[15][sd_drives-1:0];
        s.acsi_lba     = f[16];
        s.acsi_byte    = f[17][7:0];
        s.rnd          = f[18][3:0];
        s.exp_addr_s   = f[19][ram_word_bits-1:0];
        s.exp_cs       = f[20][0];
        s.exp_resb     = f[21][0];
        s.exp_rstart   = f[22][2*sd_drives-1:0];
        s.exp_wstart   = f[23][2*sd_drives-1:0];
        s.exp_sector   = f[24];
        s.exp_byte     = f[25][7:0];
        s.mask         = f[26][6:0];
        steps.push_back(s);
        total_cycles += s.rep;
      end
    end
    $fclose(fd);
  endtask

  // drive one step, idle source fields can be randomized
  task automatic apply_step(input step_t s);
    arst_n       = s.arst_n;
    ram_addr     = s.ram_addr;
    ram_ras_n    = s.ram_ras_n;
    system_reset = s.system_reset;
    sd_img_size  = s.img;
    ram_ready    = s.ram_ready;
    flash_ready  = s.flash_ready;
    reset_button = s.reset_button;
    fdc_rd       = s.fdc_rd;
    fdc_wr       = s.fdc_wr;
    acsi_rd      = s.acsi_rd;
    acsi_wr      = s.acsi_wr;
    fdc_lba      = s.rnd[0] ? $urandom : s.fdc_lba;
    fdc_wr_byte  = s.rnd[1] ? 8'($urandom) : s.fdc_byte;
    acsi_lba     = s.rnd[2] ? $urandom : s.acsi_lba;
    acsi_wr_byte = s.rnd[3] ? 8'($urandom) : s.acsi_byte;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp, input logic [31:0] tag);
    check_count++;
    if (got !== exp) begin
      $display("FAIL time %0t step %0d: %s is %h, expected %h", $time, tag, what, got, exp);
      $display("Some tests failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // mask bit order matches the stim file header
  task automatic check_outputs(input step_t s);
    if (s.mask[0]) check_value("ram_addr_s", 32'(ram_addr_s), 32'(s.exp_addr_s), s.tag);
    if (s.mask[1]) check_value("ram_cs", 32'(ram_cs), 32'(s.exp_cs), s.tag);
    if (s.mask[2]) check_value("core_resb", 32'(core_resb), 32'(s.exp_resb), s.tag);
    if (s.mask[3]) check_value("rstart", 32'(rstart), 32'(s.exp_rstart), s.tag);
    if (s.mask[4]) check_value("wstart", 32'(wstart), 32'(s.exp_wstart), s.tag);
    if (s.mask[5]) check_value("sd_sector", sd_sector, s.exp_sector, s.tag);
    if (s.mask[6]) check_value("sd_wr_byte", 32'(sd_wr_byte), 32'(s.exp_byte), s.tag);
  endtask

  initial begin
    arst_n       = 1'b0; // in reset from time 0
    ram_addr     = '0;
    ram_ras_n    = 1'b1;
    system_reset = 2'b00;
    sd_img_size  = '0;
    ram_ready    = 1'b0;
    flash_ready  = 1'b0;
    reset_button = 1'b0;
    fdc_rd       = '0;
    fdc_wr       = '0;
    fdc_lba      = '0;
    fdc_wr_byte  = '0;
    acsi_rd      = '0;
    acsi_wr      = '0;
    acsi_lba     = '0;
    acsi_wr_byte = '0;
    stim_loaded  = 1'b0;
    total_cycles = 0;
    check_count  = 0;
    seed_dummy   = $urandom(32); // seeds the generator once
    load_stim();
    stim_loaded = 1'b1;
    repeat (2) @(posedge clk_32); // reset for 2 cycles, first line releases it
    foreach (steps[i]) begin
      for (int unsigned r = 0; r < steps[i].rep; r++) begin
        #(drive_delay);
        apply_step(steps[i]);
        #(check_delay); // outputs settled, next edge still ahead
        check_outputs(steps[i]);
        @(posedge clk_32);
      end
    end
    if (check_count > 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("stim file held no checked outputs");
      $display("Some tests failed");
      $fatal(1, "nothing was checked");
    end
  end

  // watchdog, two cycles per step plus the boot wait and some slack
  initial begin
    longint unsigned limit;
    wait (stim_loaded);
    limit = (longint'(total_cycles) + boot_wait + 20) * 200;
    #(limit);
    $display("timeout: steps still running after %0d time units", limit);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: flist.f
source/mem_pkg.sv
source/disk_pkg.sv
source/ram_scrambler.sv
source/boot_gate.sv
source/sd_request_steer.sv
source/st_glue.sv
bench/st_glue_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the st_glue testbench with verilator
set -e
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f \
  --top-module st_glue_tb \
  -o st_glue_sim

# tee keeps the whole transcript for the result search below
./obj_dir/st_glue_sim 2>&1 | tee "$log"

if grep -q "Some tests failed" "$log"; then
  echo "simulation reported a failure, see $log"
  exit 1
fi

if ! grep -q "All tests passed" "$log"; then
  echo "simulation ended without a result line, see $log"
  exit 1
fi

echo "simulation finished cleanly, log in $log"

// File: bench/st_glue_stim.txt
# tag rep arst addr ras sr img rrdy frdy btn frd fwr flba fby ard awr alba aby rnd, then expected:
# addr_s cs resb rstart wstart sector byte mask (mask bits 0..6 = addr_s cs resb rst wst sec byte)
1 1 1 123456 1 0 0 1 1 0 0 0 100 11 0 0 0 0 c 123456 0 0 0 0 100 11 7f
2 2 1 123456 0 0 0 1 1 0 0 0 100 11 0 0 0 0 c 123456 1 0 0 0 100 11 7f
3 1 1 6abcde 0 0 0 1 1 0 0 0 100 11 0 0 0 0 c 2abcde 0 0 0 0 100 11 7f
4 1 1 3fffff 0 0 0 1 1 0 0 0 100 11 0 0 0 0 c 3fffff 1 0 0 0 100 11 7f
5 1 1 123456 1 2 0 1 1 0 0 0 100 11 0 0 0 0 c 123456 0 0 0 0 100 11 7f
6 3 1 123456 1 2 0 1 1 0 0 0 100 11 0 0 0 0 c 123452 0 0 0 0 100 11 7f
7 1 1 123456 0 0 0 1 1 0 0 0 100 11 0 0 0 0 c 123452 1 0 0 0 100 11 7f
8 1 1 123456 1 2 0 1 1 0 0 0 100 11 0 0 0 0 c 123452 0 0 0 0 100 11 7f
9 1 1 123456 1 0 0 1 1 0 0 0 100 11 0 0 0 0 c 12345e 0 0 0 0 100 11 7f
10 1 1 123456 1 2 0 1 1 0 0 0 100 11 0 0 0 0 c 12345e 0 0 0 0 100 11 7f
11 1 1 123456 1 0 0 1 1 0 0 0 100 11 0 0 0 0 c 12345a 0 0 0 0 100 11 7f
12 1 1 123456 1 2 0 1 1 0 0 0 100 11 0 0 0 0 c 12345a 0 0 0 0 100 11 7f
13 2 1 123456 1 2 0 1 1 0 0 0 100 11 0 0 0 0 c 123456 0 0 0 0 100 11 7f
14 1 1 123456 1 0 0 1 1 0 0 0 100 11 0 0 0 0 c 123456 0 0 0 0 100 11 7f
15 1 1 123456 1 0 0 1 1 0 0 0 100 11 0 0 0 0 c 123456 0 0 0 0 100 11 7f
16 1 1 123456 1 0 100000 1 1 0 0 0 100 11 0 0 0 0 c 123456 0 0 0 0 100 11 7f
17 1 1 123456 1 0 100000 1 1 0 0 0 100 11 0 0 0 0 c 123456 0 1 0 0 100 11 7f
18 1 1 123456 1 0 100000 0 1 0 0 0 100 11 0 0 0 0 c 123456 0 0 0 0 100 11 7f
19 1 1 123456 1 0 100000 1 0 0 0 0 100 11 0 0 0 0 c 123456 0 0 0 0 100 11 7f
20 1 1 123456 1 0 100000 1 1 1 0 0 100 11 0 0 0 0 c 123456 0 0 0 0 100 11 7f
21 1 1 123456 1 1 100000 1 1 0 0 0 100 11 0 0 0 0 c 123456 0 0 0 0 100 11 7f
22 1 1 123456 1 0 0 1 1 0 0 0 100 11 0 0 0 0 c 123456 0 1 0 0 100 11 7f
23 1 1 123456 1 0 0 1 1 0 0 0 a000 5a 0 0 0 0 c 123456 0 1 0 0 a000 5a 7f
24 1 1 123456 1 0 0 1 1 0 0 0 0 0 1 0 c0ffee a5 3 123456 0 1 4 0 c0ffee a5 7f
25 3 1 123456 1 0 0 1 1 0 0 0 0 0 0 0 c0ffee a5 3 123456 0 1 0 0 c0ffee a5 7f
26 1 1 123456 1 0 0 1 1 0 0 0 0 0 0 2 c0ffee a5 3 123456 0 1 0 8 c0ffee a5 7f
27 1 1 123456 1 0 0 1 1 0 2 0 a000 5a 0 0 c0ffee a5 0 123456 0 1 2 0 c0ffee a5 7f
28 1 1 123456 1 0 0 1 1 0 0 0 a000 5a 0 0 0 0 c 123456 0 1 0 0 a000 5a 7f
29 1 1 123456 1 0 0 1 1 0 0 1 a000 5a 0 0 0 0 c 123456 0 1 0 1 a000 5a 7f
30 1 1 123456 1 0 0 1 1 0 3 3 a000 5a 0 0 0 0 c 123456 0 1 3 3 a000 5a 7f
31 1 1 123456 1 0 0 1 1 0 0 0 0 0 3 0 c0ffee a5 3 123456 0 1 c 0 c0ffee a5 7f
32 1 1 123456 1 2 0 1 1 0 0 0 0 0 0 0 c0ffee a5 3 123456 0 1 0 0 c0ffee a5 7f
33 2 0 123456 1 0 0 1 1 0 0 0 a000 5a 0 0 0 0 c 123456 0 0 0 0 a000 5a 7f
34 40 1 123456 1 0 0 1 1 0 0 0 a000 5a 0 0 0 0 c 123456 0 0 0 0 a000 5a 7f
35 1 1 123456 1 0 0 1 1 0 0 0 a000 5a 0 0 0 0 c 123456 0 0 0 0 a000 5a 7b
36 3 1 123456 1 0 0 1 1 0 0 0 a000 5a 0 0 0 0 c 123456 0 1 0 0 a000 5a 7f
37 1 1 123456 1 1 0 1 1 0 0 0 a000 5a 0 0 0 0 c 123456 0 0 0 0 a000 5a 7f
